//--- rtl/ex_pkg.sv
package ex_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // major opcodes
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101; // srl / sra by bit 30
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef logic [3:0] alu_op_t;

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SLT  = 4'd3;
    localparam alu_op_t ALU_SLTU = 4'd4;
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_AND  = 4'd9;

    localparam word_t LINK_OFFSET = 32'd4; // pc + 4 for jal / jalr

    // one instruction word, six views
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            reg_addr_t  rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm;
            reg_addr_t   rs1;
            logic [2:0]  funct3;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo; // sits where rd would be
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            reg_addr_t  rd;
            logic [6:0] opcode;
        } j_fmt;
    } inst_u;

endpackage

//--- rtl/ex_op_if.sv
`timescale 1ns/10ps

interface ex_op_if;

    ex_pkg::word_t   op1;
    ex_pkg::word_t   op2;
    ex_pkg::alu_op_t alu_op;
    ex_pkg::word_t   jump_base;
    ex_pkg::word_t   jump_offset;
    logic [2:0]      funct3;
    logic            is_branch;
    logic            is_jump;
    logic            jalr; // clear target bit 0

    modport src (output op1, op2, alu_op, jump_base, jump_offset,
                        funct3, is_branch, is_jump, jalr);

    modport alu (input op1, op2, alu_op);

    modport br (input op1, op2, jump_base, jump_offset,
                      funct3, is_branch, is_jump, jalr);

endinterface

//--- rtl/ex_res_if.sv
`timescale 1ns/10ps

interface ex_res_if;

    // from decode
    logic                reg_w_ena;
    ex_pkg::reg_addr_t   reg_w_addr;
    logic                mem_r_ena;
    logic                mem_w_ena;
    logic [2:0]          mem_funct3;
    ex_pkg::word_t       mem_w_data;

    ex_pkg::word_t       alu_res;   // from alu

    logic                jump_flag; // from branch unit
    ex_pkg::word_t       jump_addr;

    modport ctrl (output reg_w_ena, reg_w_addr, mem_r_ena, mem_w_ena,
                         mem_funct3, mem_w_data);

    modport alu (output alu_res);

    modport br (output jump_flag, jump_addr);

    modport sink (input reg_w_ena, reg_w_addr, mem_r_ena, mem_w_ena,
                        mem_funct3, mem_w_data, alu_res, jump_flag, jump_addr);

endinterface

//--- rtl/ex_decode.sv
`timescale 1ns/10ps

module ex_decode (
    input  ex_pkg::inst_u inst_i,
    input  ex_pkg::word_t inst_addr_i,
    input  ex_pkg::word_t rs1_data_i,
    input  ex_pkg::word_t rs2_data_i,
    ex_op_if.src          op,
    ex_res_if.ctrl        res
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            alt;       // inst bit 30
    ex_pkg::alu_op_t arith_op;
    ex_pkg::word_t   imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = inst_i.r_fmt.opcode;
    assign funct3 = inst_i.r_fmt.funct3;
    assign alt    = inst_i.r_fmt.funct7[5];

    assign imm_i = {{20{inst_i.i_fmt.imm[11]}}, inst_i.i_fmt.imm};
    assign imm_s = {{20{inst_i.s_fmt.imm_hi[6]}}, inst_i.s_fmt.imm_hi, inst_i.s_fmt.imm_lo};
    assign imm_b = {{19{inst_i.b_fmt.imm_12}}, inst_i.b_fmt.imm_12, inst_i.b_fmt.imm_11,
                    inst_i.b_fmt.imm_10_5, inst_i.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {inst_i.u_fmt.imm, 12'b0};
    assign imm_j = {{11{inst_i.j_fmt.imm_20}}, inst_i.j_fmt.imm_20, inst_i.j_fmt.imm_19_12,
                    inst_i.j_fmt.imm_11, inst_i.j_fmt.imm_10_1, 1'b0};

    assign res.reg_w_addr = inst_i.r_fmt.rd;
    assign res.mem_funct3 = funct3;     // load/store width
    assign res.mem_w_data = rs2_data_i;

    always_comb begin
        case (funct3)
            ex_pkg::F3_ADD_SUB: arith_op = (alt && opcode == ex_pkg::OP_REG) ?
                                           ex_pkg::ALU_SUB : ex_pkg::ALU_ADD; // no subi
            ex_pkg::F3_SLL:     arith_op = ex_pkg::ALU_SLL;
            ex_pkg::F3_SLT:     arith_op = ex_pkg::ALU_SLT;
            ex_pkg::F3_SLTU:    arith_op = ex_pkg::ALU_SLTU;
            ex_pkg::F3_XOR:     arith_op = ex_pkg::ALU_XOR;
            ex_pkg::F3_SR:      arith_op = alt ? ex_pkg::ALU_SRA : ex_pkg::ALU_SRL;
            ex_pkg::F3_OR:      arith_op = ex_pkg::ALU_OR;
            default:            arith_op = ex_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        op.op1         = rs1_data_i;
        op.op2         = rs2_data_i;
        op.alu_op      = ex_pkg::ALU_ADD;
        op.jump_base   = inst_addr_i;
        op.jump_offset = imm_b;
        op.funct3      = funct3;
        op.is_branch   = 1'b0;
        op.is_jump     = 1'b0;
        op.jalr        = 1'b0;
        res.reg_w_ena  = 1'b0;
        res.mem_r_ena  = 1'b0;
        res.mem_w_ena  = 1'b0;
        case (opcode)
            ex_pkg::OP_REG: begin
                op.alu_op     = arith_op;
                res.reg_w_ena = 1'b1;
            end
            ex_pkg::OP_IMM: begin
                op.op2        = imm_i;      // shamt in low 5 bits
                op.alu_op     = arith_op;
                res.reg_w_ena = 1'b1;
            end
            ex_pkg::OP_LOAD: begin
                op.op2        = imm_i;
                res.mem_r_ena = 1'b1;
                res.reg_w_ena = 1'b1;
            end
            ex_pkg::OP_STORE: begin
                op.op2        = imm_s;
                res.mem_w_ena = 1'b1;
            end
            ex_pkg::OP_BRANCH: op.is_branch = 1'b1;
            ex_pkg::OP_JAL, ex_pkg::OP_JALR: begin
                op.op1        = inst_addr_i;  // link value
                op.op2        = ex_pkg::LINK_OFFSET;
                op.is_jump    = 1'b1;
                res.reg_w_ena = 1'b1;
                if (opcode == ex_pkg::OP_JALR) begin
                    op.jump_base   = rs1_data_i;
                    op.jump_offset = imm_i;
                    op.jalr        = 1'b1;
                end else begin
                    op.jump_offset = imm_j;
                end
            end
            ex_pkg::OP_LUI: begin
                op.op1        = imm_u;
                op.op2        = '0;
                res.reg_w_ena = 1'b1;
            end
            ex_pkg::OP_AUIPC: begin
                op.op1        = inst_addr_i;
                op.op2        = imm_u;
                res.reg_w_ena = 1'b1;
            end
            default: ;
        endcase
        if (inst_i.r_fmt.rd == '0) begin
            res.reg_w_ena = 1'b0;   // x0 is never written
        end
        assert (!(res.mem_r_ena && res.mem_w_ena))
            else $error("load and store enables both high");
    end

endmodule

//--- rtl/ex_alu.sv
`timescale 1ns/10ps

module ex_alu (
    ex_op_if.alu  op,
    ex_res_if.alu res
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;
    ex_pkg::word_t sum;

    assign shamt = op.op2[4:0];
    assign lt_s  = $signed(op.op1) < $signed(op.op2);
    assign lt_u  = op.op1 < op.op2;
    assign sum   = op.op1 + op.op2; // also addresses, link, lui, auipc

    always_comb begin
        case (op.alu_op)
            ex_pkg::ALU_ADD:  res.alu_res = sum;
            ex_pkg::ALU_SUB:  res.alu_res = op.op1 - op.op2;
            ex_pkg::ALU_SLL:  res.alu_res = op.op1 << shamt;
            ex_pkg::ALU_SLT:  res.alu_res = {{(ex_pkg::XLEN-1){1'b0}}, lt_s};
            ex_pkg::ALU_SLTU: res.alu_res = {{(ex_pkg::XLEN-1){1'b0}}, lt_u};
            ex_pkg::ALU_XOR:  res.alu_res = op.op1 ^ op.op2;
            ex_pkg::ALU_SRL:  res.alu_res = op.op1 >> shamt;
            ex_pkg::ALU_SRA:  res.alu_res = ex_pkg::word_t'($signed(op.op1) >>> shamt);
            ex_pkg::ALU_OR:   res.alu_res = op.op1 | op.op2;
            ex_pkg::ALU_AND:  res.alu_res = op.op1 & op.op2;
            default:          res.alu_res = '0;
        endcase
    end

endmodule

//--- rtl/ex_branch.sv
`timescale 1ns/10ps

module ex_branch (
    ex_op_if.br  op,
    ex_res_if.br res
);

    logic          eq;
    logic          lt_s;
    logic          lt_u;
    logic          cond;
    ex_pkg::word_t target;

    assign eq     = op.op1 == op.op2;
    assign lt_s   = $signed(op.op1) < $signed(op.op2);
    assign lt_u   = op.op1 < op.op2;
    assign target = op.jump_base + op.jump_offset;

    assign res.jump_addr = {target[ex_pkg::XLEN-1:1], target[0] & ~op.jalr};

    always_comb begin
        case (op.funct3)
            ex_pkg::F3_BEQ:  cond = eq;
            ex_pkg::F3_BNE:  cond = !eq;
            ex_pkg::F3_BLT:  cond = lt_s;
            ex_pkg::F3_BGE:  cond = !lt_s;
            ex_pkg::F3_BLTU: cond = lt_u;
            ex_pkg::F3_BGEU: cond = !lt_u;
            default:         cond = 1'b0;  // reserved encodings
        endcase
        res.jump_flag = op.is_jump || (op.is_branch && cond);
        assert (!res.jump_flag || op.is_branch || op.is_jump)
            else $error("jump_flag set for a non-control instruction");
    end

endmodule

//--- rtl/ex_out_reg.sv
`timescale 1ns/10ps

module ex_out_reg (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              in_valid_i,
    input  logic              out_ready_i,
    output logic              in_ready_o,
    output logic              out_valid_o,
    ex_res_if.sink            res,
    output logic              reg_w_ena_o,
    output ex_pkg::reg_addr_t reg_w_addr_o,
    output ex_pkg::word_t     reg_w_data_o,
    output logic              mem_r_ena_o,
    output logic              mem_w_ena_o,
    output ex_pkg::word_t     mem_addr_o,
    output ex_pkg::word_t     mem_w_data_o,
    output logic [2:0]        mem_funct3_o,
    output logic              jump_flag_o,
    output ex_pkg::word_t     jump_addr_o
);

    logic accept;
    logic mem_op;

    assign in_ready_o = !out_valid_o || out_ready_i; // empty or draining
    assign accept     = in_valid_i && in_ready_o;
    assign mem_op     = res.mem_r_ena || res.mem_w_ena;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
            reg_w_ena_o <= 1'b0;
            mem_r_ena_o <= 1'b0;
            mem_w_ena_o <= 1'b0;
            jump_flag_o <= 1'b0;
        end else if (accept) begin
            out_valid_o <= 1'b1;
            reg_w_ena_o <= res.reg_w_ena;
            mem_r_ena_o <= res.mem_r_ena;
            mem_w_ena_o <= res.mem_w_ena;
            jump_flag_o <= res.jump_flag;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            reg_w_addr_o <= res.reg_w_addr;
            reg_w_data_o <= mem_op ? '0 : res.alu_res;
            mem_addr_o   <= mem_op ? res.alu_res : '0; // effective address
            mem_w_data_o <= res.mem_w_data;
            mem_funct3_o <= res.mem_funct3;
            jump_addr_o  <= res.jump_addr;
        end
    end

    a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i |=> $stable({out_valid_o, reg_w_ena_o, reg_w_addr_o,
            reg_w_data_o, mem_r_ena_o, mem_w_ena_o, mem_addr_o, mem_w_data_o,
            mem_funct3_o, jump_flag_o, jump_addr_o}));

endmodule

//--- rtl/ex_stage.sv
`timescale 1ns/10ps

module ex_stage (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  logic [31:0]       inst_i,
    input  ex_pkg::word_t     inst_addr_i,
    input  ex_pkg::word_t     rs1_data_i,
    input  ex_pkg::word_t     rs2_data_i,
    output logic              out_valid_o,
    input  logic              out_ready_i,
    output logic              reg_w_ena_o,
    output ex_pkg::reg_addr_t reg_w_addr_o,
    output ex_pkg::word_t     reg_w_data_o,
    output logic              mem_r_ena_o,
    output logic              mem_w_ena_o,
    output ex_pkg::word_t     mem_addr_o,
    output ex_pkg::word_t     mem_w_data_o,
    output logic [2:0]        mem_funct3_o,
    output logic              jump_flag_o,
    output ex_pkg::word_t     jump_addr_o
);

    ex_op_if  op_bus ();
    ex_res_if res_bus ();

    ex_decode u_decode (
        .inst_i      (inst_i),
        .inst_addr_i (inst_addr_i),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .op          (op_bus.src),
        .res         (res_bus.ctrl)
    );

    ex_alu u_alu (
        .op  (op_bus.alu),
        .res (res_bus.alu)
    );

    ex_branch u_branch (
        .op  (op_bus.br),
        .res (res_bus.br)
    );

    ex_out_reg u_out_reg (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .in_valid_i   (in_valid_i),
        .out_ready_i  (out_ready_i),
        .in_ready_o   (in_ready_o),
        .out_valid_o  (out_valid_o),
        .res          (res_bus.sink),
        .reg_w_ena_o  (reg_w_ena_o),
        .reg_w_addr_o (reg_w_addr_o),
        .reg_w_data_o (reg_w_data_o),
        .mem_r_ena_o  (mem_r_ena_o),
        .mem_w_ena_o  (mem_w_ena_o),
        .mem_addr_o   (mem_addr_o),
        .mem_w_data_o (mem_w_data_o),
        .mem_funct3_o (mem_funct3_o),
        .jump_flag_o  (jump_flag_o),
        .jump_addr_o  (jump_addr_o)
    );

endmodule

//--- test/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o; // 4 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

//--- test/ex_stage_tb.sv
`timescale 1ns/10ps

module ex_stage_tb;

    typedef struct packed {
        logic [31:0]       inst;
        ex_pkg::word_t     pc;
        ex_pkg::word_t     rs1;
        ex_pkg::word_t     rs2;
        logic              w_ena;
        ex_pkg::reg_addr_t w_addr;
        ex_pkg::word_t     w_data;
        logic              r_mem;
        logic              w_mem;
        ex_pkg::word_t     m_addr;
        logic              jump;
        logic              ctl;    // branch or jump
        ex_pkg::word_t     target;
    } row_t;

    logic clk;
    logic rst_n;
    logic in_valid_i;
    logic in_ready_o;
    logic [31:0] inst_i;
    ex_pkg::word_t inst_addr_i;
    ex_pkg::word_t rs1_data_i;
    ex_pkg::word_t rs2_data_i;
    logic out_valid_o;
    logic out_ready_i;
    logic reg_w_ena_o;
    ex_pkg::reg_addr_t reg_w_addr_o;
    ex_pkg::word_t reg_w_data_o;
    logic mem_r_ena_o;
    logic mem_w_ena_o;
    ex_pkg::word_t mem_addr_o;
    ex_pkg::word_t mem_w_data_o;
    logic [2:0] mem_funct3_o;
    logic jump_flag_o;
    ex_pkg::word_t jump_addr_o;

    row_t rows[$];
    int   err_value;
    int   err_timeout;
    logic hung;

    tb_clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    ex_stage dut0 (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .inst_i       (inst_i),
        .inst_addr_i  (inst_addr_i),
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .reg_w_ena_o  (reg_w_ena_o),
        .reg_w_addr_o (reg_w_addr_o),
        .reg_w_data_o (reg_w_data_o),
        .mem_r_ena_o  (mem_r_ena_o),
        .mem_w_ena_o  (mem_w_ena_o),
        .mem_addr_o   (mem_addr_o),
        .mem_w_data_o (mem_w_data_o),
        .mem_funct3_o (mem_funct3_o),
        .jump_flag_o  (jump_flag_o),
        .jump_addr_o  (jump_addr_o)
    );

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, 5'd2, 5'd1, f3, rd, ex_pkg::OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [11:0] imm,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, 5'd1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], ex_pkg::OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], ex_pkg::OP_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] opc, input logic [19:0] imm,
                                           input logic [4:0] rd);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, ex_pkg::OP_JAL};
    endfunction

    // RV32I integer result, bit 30 selects sub only in register form
    function automatic ex_pkg::word_t arith(input logic [2:0] f3, input logic bit30,
                                            input logic reg_form, input ex_pkg::word_t a,
                                            input ex_pkg::word_t b);
        case (f3)
            3'd0: begin
                if (bit30 && reg_form)
                    return a - b;
                return a + b;
            end
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (bit30)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input ex_pkg::word_t a,
                                          input ex_pkg::word_t b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            3'b111: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic row_t expect_row(input logic [31:0] inst, input ex_pkg::word_t pc,
                                        input ex_pkg::word_t rs1, input ex_pkg::word_t rs2);
        row_t          r;
        logic          reg_form;
        ex_pkg::word_t imm_i;
        ex_pkg::word_t imm_s;
        ex_pkg::word_t imm_b;
        ex_pkg::word_t imm_u;
        ex_pkg::word_t imm_j;
        imm_i    = {{20{inst[31]}}, inst[31:20]};
        imm_s    = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_b    = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_u    = {inst[31:12], 12'h000};
        imm_j    = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        reg_form = inst[6:0] == ex_pkg::OP_REG;
        r        = '0;
        r.inst   = inst;
        r.pc     = pc;
        r.rs1    = rs1;
        r.rs2    = rs2;
        r.w_addr = inst[11:7];
        case (inst[6:0])
            ex_pkg::OP_REG, ex_pkg::OP_IMM: begin
                r.w_ena  = 1'b1;
                r.w_data = arith(inst[14:12], inst[30], reg_form, rs1, reg_form ? rs2 : imm_i);
            end
            ex_pkg::OP_LOAD: begin
                r.w_ena  = 1'b1;
                r.r_mem  = 1'b1;
                r.m_addr = rs1 + imm_i;
            end
            ex_pkg::OP_STORE: begin
                r.w_mem  = 1'b1;
                r.m_addr = rs1 + imm_s;
            end
            ex_pkg::OP_BRANCH: begin
                r.ctl    = 1'b1;
                r.jump   = branch_taken(inst[14:12], rs1, rs2);
                r.target = pc + imm_b;
            end
            ex_pkg::OP_JAL: begin
                r.w_ena  = 1'b1;
                r.w_data = pc + 32'd4;
                r.ctl    = 1'b1;
                r.jump   = 1'b1;
                r.target = pc + imm_j;
            end
            ex_pkg::OP_JALR: begin
                r.w_ena  = 1'b1;
                r.w_data = pc + 32'd4;
                r.ctl    = 1'b1;
                r.jump   = 1'b1;
                r.target = (rs1 + imm_i) & 32'hFFFF_FFFE;
            end
            ex_pkg::OP_LUI: begin
                r.w_ena  = 1'b1;
                r.w_data = imm_u;
            end
            ex_pkg::OP_AUIPC: begin
                r.w_ena  = 1'b1;
                r.w_data = pc + imm_u;
            end
            default: ;
        endcase
        if (inst[11:7] == 5'd0)
            r.w_ena = 1'b0; // x0
        return r;
    endfunction

    task automatic add_row(input logic [31:0] inst, input ex_pkg::word_t pc,
                           input ex_pkg::word_t rs1, input ex_pkg::word_t rs2);
        rows.push_back(expect_row(inst, pc, rs1, rs2));
    endtask

    task automatic build_table();
        add_row(r_type(7'h00, ex_pkg::F3_ADD_SUB, 5'd1), 32'h100, 32'd5, 32'd7);
        add_row(r_type(7'h20, ex_pkg::F3_ADD_SUB, 5'd2), 32'h104, 32'd3, 32'd10);
        add_row(r_type(7'h00, ex_pkg::F3_SLL, 5'd3), 32'h108, 32'h1, 32'hFFFF_FFFF);
        add_row(r_type(7'h00, ex_pkg::F3_SLT, 5'd4), 32'h10C, 32'hFFFF_FFFF, 32'h1);
        add_row(r_type(7'h00, ex_pkg::F3_SLTU, 5'd5), 32'h110, 32'hFFFF_FFFF, 32'h1);
        add_row(r_type(7'h00, ex_pkg::F3_XOR, 5'd6), 32'h114, 32'hF0F0_1234, 32'h0FF0_4321);
        add_row(r_type(7'h00, ex_pkg::F3_SR, 5'd7), 32'h118, 32'h8000_0010, 32'd4);
        add_row(r_type(7'h20, ex_pkg::F3_SR, 5'd8), 32'h11C, 32'h8000_0010, 32'd4);
        add_row(r_type(7'h00, ex_pkg::F3_OR, 5'd9), 32'h120, 32'hF000_000F, 32'h0000_0FF0);
        add_row(r_type(7'h00, ex_pkg::F3_AND, 5'd10), 32'h124, 32'hF0F0_F0F0, 32'hFF00_FF00);
        add_row(r_type(7'h00, ex_pkg::F3_ADD_SUB, 5'd0), 32'h128, 32'd1, 32'd2);
        add_row(i_type(ex_pkg::OP_IMM, 12'hFFF, ex_pkg::F3_ADD_SUB, 5'd11), 32'h200, 32'd10, 32'd0);
        add_row(i_type(ex_pkg::OP_IMM, 12'h7FF, ex_pkg::F3_ADD_SUB, 5'd12), 32'h204, 32'd1, 32'd0);
        add_row(i_type(ex_pkg::OP_IMM, 12'hFFF, ex_pkg::F3_SLT, 5'd13), 32'h208, 32'hFFFF_FFFE, 32'd0);
        add_row(i_type(ex_pkg::OP_IMM, 12'hFFF, ex_pkg::F3_SLTU, 5'd14), 32'h20C, 32'd5, 32'd0);
        add_row(i_type(ex_pkg::OP_IMM, 12'h0F0, ex_pkg::F3_XOR, 5'd15), 32'h210, 32'h1234_5678, 32'd0);
        add_row(i_type(ex_pkg::OP_IMM, 12'h800, ex_pkg::F3_OR, 5'd16), 32'h214, 32'h0000_0001, 32'd0);
        add_row(i_type(ex_pkg::OP_IMM, 12'h0FF, ex_pkg::F3_AND, 5'd17), 32'h218, 32'hABCD_EF12, 32'd0);
        add_row(i_type(ex_pkg::OP_IMM, 12'h003, ex_pkg::F3_SLL, 5'd18), 32'h21C, 32'h1000_0001, 32'd0);
        add_row(i_type(ex_pkg::OP_IMM, 12'h008, ex_pkg::F3_SR, 5'd19), 32'h220, 32'hF000_0000, 32'd0);
        add_row(i_type(ex_pkg::OP_IMM, 12'h408, ex_pkg::F3_SR, 5'd20), 32'h224, 32'hF000_0000, 32'd0);
        add_row(i_type(ex_pkg::OP_LOAD, 12'hFFC, 3'b010, 5'd21), 32'h300, 32'h1000, 32'd0);
        add_row(i_type(ex_pkg::OP_LOAD, 12'h010, 3'b100, 5'd22), 32'h304, 32'h1000, 32'd0);
        add_row(s_type(12'hFF8, 3'b010), 32'h308, 32'h2000, 32'hDEAD_BEEF);
        add_row(s_type(12'h005, 3'b000), 32'h30C, 32'h2000, 32'h0000_00A5);
        add_row(b_type(13'h0010, ex_pkg::F3_BEQ), 32'h400, 32'd5, 32'd5);
        add_row(b_type(13'h1FF8, ex_pkg::F3_BEQ), 32'h404, 32'd5, 32'd6);
        add_row(b_type(13'h0010, ex_pkg::F3_BNE), 32'h408, 32'd5, 32'd5);
        add_row(b_type(13'h1FF8, ex_pkg::F3_BNE), 32'h40C, 32'd5, 32'd6);
        add_row(b_type(13'h0020, ex_pkg::F3_BLT), 32'h410, 32'hFFFF_FFFF, 32'd1);
        add_row(b_type(13'h0020, ex_pkg::F3_BLT), 32'h414, 32'd1, 32'hFFFF_FFFF);
        add_row(b_type(13'h1FF0, ex_pkg::F3_BGE), 32'h418, 32'd1, 32'hFFFF_FFFF);
        add_row(b_type(13'h1FF0, ex_pkg::F3_BGE), 32'h41C, 32'hFFFF_FFFF, 32'd1);
        add_row(b_type(13'h0800, ex_pkg::F3_BGE), 32'h420, 32'd7, 32'd7);
        add_row(b_type(13'h0040, ex_pkg::F3_BLTU), 32'h424, 32'd1, 32'hFFFF_FFFF);
        add_row(b_type(13'h0040, ex_pkg::F3_BLTU), 32'h428, 32'hFFFF_FFFF, 32'd1);
        add_row(b_type(13'h1000, ex_pkg::F3_BGEU), 32'h42C, 32'hFFFF_FFFF, 32'd1);
        add_row(b_type(13'h1000, ex_pkg::F3_BGEU), 32'h430, 32'd1, 32'hFFFF_FFFF);
        add_row(j_type(21'h000804, 5'd1), 32'h500, 32'd0, 32'd0);
        add_row(j_type(21'h1FFFF0, 5'd1), 32'h504, 32'd0, 32'd0);
        add_row(i_type(ex_pkg::OP_JALR, 12'h004, 3'b000, 5'd1), 32'h600, 32'h2001, 32'd0);
        add_row(i_type(ex_pkg::OP_JALR, 12'hFFF, 3'b000, 5'd0), 32'h604, 32'h3000, 32'd0);
        add_row(u_type(ex_pkg::OP_LUI, 20'hABCDE, 5'd5), 32'h700, 32'd0, 32'd0);
        add_row(u_type(ex_pkg::OP_AUIPC, 20'h12345, 5'd6), 32'h704, 32'd0, 32'd0);
        add_row(u_type(ex_pkg::OP_AUIPC, 20'hFFFFF, 5'd7), 32'h2000, 32'd0, 32'd0);
    endtask

    task automatic check_word(input string name, input ex_pkg::word_t act,
                              input ex_pkg::word_t exp);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
            err_value++;
        end
    endtask

    task automatic check_addr(input string name, input ex_pkg::reg_addr_t act,
                              input ex_pkg::reg_addr_t exp);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
            err_value++;
        end
    endtask

    task automatic check_funct3(input string name, input logic [2:0] act, input logic [2:0] exp);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
            err_value++;
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
            err_value++;
        end
    endtask

    task automatic compare_row(input row_t e);
        check_bit("reg_w_ena_o", reg_w_ena_o, e.w_ena);
        check_bit("mem_r_ena_o", mem_r_ena_o, e.r_mem);
        check_bit("mem_w_ena_o", mem_w_ena_o, e.w_mem);
        check_bit("jump_flag_o", jump_flag_o, e.jump);
        if (e.w_ena)
            check_addr("reg_w_addr_o", reg_w_addr_o, e.w_addr);
        if (e.w_ena && !e.r_mem)
            check_word("reg_w_data_o", reg_w_data_o, e.w_data);
        if (e.r_mem || e.w_mem) begin
            check_word("mem_addr_o", mem_addr_o, e.m_addr);
            check_funct3("mem_funct3_o", mem_funct3_o, e.inst[14:12]);
        end
        if (e.w_mem)
            check_word("mem_w_data_o", mem_w_data_o, e.rs2);
        if (e.ctl)
            check_word("jump_addr_o", jump_addr_o, e.target);
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!rst_n && n < 10);
        if (!rst_n) begin
            $display("timeout: reset was never released");
            err_timeout++;
            hung = 1'b1;
        end
    endtask

    task automatic check_reset();
        @(negedge clk);
        #1;
        check_bit("out_valid_o", out_valid_o, 1'b0);
        check_bit("in_ready_o", in_ready_o, 1'b1);
        check_bit("reg_w_ena_o", reg_w_ena_o, 1'b0);
        check_bit("mem_r_ena_o", mem_r_ena_o, 1'b0);
        check_bit("mem_w_ena_o", mem_w_ena_o, 1'b0);
        check_bit("jump_flag_o", jump_flag_o, 1'b0);
    endtask

    // streams the whole table, results must come back once each and in order
    task automatic run_table(input logic gaps);
        int   sent;
        int   taken;
        int   in_wait;
        int   out_wait;
        int   cycles;
        logic took_in;
        sent     = 0;
        taken    = 0;
        in_wait  = 0;
        out_wait = 0;
        cycles   = 0;
        took_in  = 1'b0;
        while (!hung && taken < rows.size()) begin
            @(negedge clk);
            if (took_in)
                check_bit("out_valid_o", out_valid_o, 1'b1); // one edge after accept
            in_valid_i = sent < rows.size();
            if (sent < rows.size()) begin
                inst_i      = rows[sent].inst;
                inst_addr_i = rows[sent].pc;
                rs1_data_i  = rows[sent].rs1;
                rs2_data_i  = rows[sent].rs2;
            end
            out_ready_i = gaps ? ($urandom % 4 != 0) : 1'b1;
            #1;
            took_in = in_valid_i && in_ready_o;
            if (out_valid_o && out_ready_i) begin
                if (taken >= sent) begin
                    $display("result at %0t has no matching instruction", $time);
                    err_value++;
                end else begin
                    compare_row(rows[taken]);
                end
                taken++;
            end
            if (in_valid_i && !in_ready_o)
                in_wait++;
            else
                in_wait = 0;
            if (!out_valid_o && taken < sent)
                out_wait++;
            else
                out_wait = 0;
            if (took_in)
                sent++;
            cycles++;
            if (in_wait > 20 || out_wait > 20 || cycles > 1000) begin
                $display("timeout at %0t: handshake stuck, %0d sent, %0d taken",
                         $time, sent, taken);
                err_timeout++;
                hung = 1'b1;
            end
        end
        @(negedge clk);
        in_valid_i  = 1'b0;
        out_ready_i = 1'b1;
        #1;
        if (!hung && out_valid_o) begin
            $display("extra result after the last row at %0t", $time);
            err_value++;
        end
    endtask

    initial begin
        void'($urandom(32'h9901));
        in_valid_i  = 1'b0;
        inst_i      = '0;
        inst_addr_i = '0;
        rs1_data_i  = '0;
        rs2_data_i  = '0;
        out_ready_i = 1'b1;
        err_value   = 0;
        err_timeout = 0;
        hung        = 1'b0;
        build_table();
        wait_reset();
        if (!hung)
            check_reset();
        run_table(1'b0);
        run_table(1'b1); // random sink stalls
        $display("errors: %0d mismatches, %0d timeouts", err_value, err_timeout);
        if (err_value == 0 && err_timeout == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- verilog.f
rtl/ex_pkg.sv
rtl/ex_op_if.sv
rtl/ex_res_if.sv
rtl/ex_decode.sv
rtl/ex_alu.sv
rtl/ex_branch.sv
rtl/ex_out_reg.sv
rtl/ex_stage.sv
test/tb_clk_gen.sv
test/ex_stage_tb.sv

//--- Makefile
SIM      := verilator
TOP      := ex_stage_tb
FILELIST := verilog.f
FLAGS    := --binary --timing --assert --timescale 1ns/10ps
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := === PASS ===

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qF -- '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
